/* verilog.f */
logic/cpu_pkg.sv
logic/pipe_reg.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/exec_mem_top.sv
verif/exec_mem_asserts.sv
verif/exec_mem_tb.sv

/* Makefile */
SIM     := obj_dir/Vexec_mem_tb
SOURCES := $(filter-out +%,$(shell cat verilog.f))
LOG     := sim.log

.PHONY: all run check clean

all: run

$(SIM): verilog.f $(SOURCES)
	verilator --binary --timing --assert --top-module exec_mem_tb -f verilog.f -o Vexec_mem_tb

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* verif/exec_mem_stim.txt */
# test flush pc a b imm alu_op br_op is_branch rd reg_write mem_read mem_write mem_to_reg wwd
# then expected: redirect_valid target reg_write rd wb_data wwd_valid wwd_data (all hex)
1 0 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
1 0 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
2 0 0000 8421 0f0f 0012 0 0 0 1 1 0 0 0 0  0 0000 1 1 9330 0 0000
2 0 0000 8421 0f0f 0012 1 0 0 2 1 0 0 0 0  0 0000 1 2 7512 0 0000
2 0 0000 8421 0f0f 0012 2 0 0 3 1 0 0 0 0  0 0000 1 3 0401 0 0000
2 0 0000 8421 0f0f 0012 3 0 0 0 1 0 0 0 0  0 0000 1 0 8f2f 0 0000
2 0 0000 8421 0f0f 0012 4 0 0 1 1 0 0 0 0  0 0000 1 1 7bde 0 0000
2 0 0000 8421 0f0f 0012 5 0 0 2 1 0 0 0 0  0 0000 1 2 7bdf 0 0000
2 0 0000 8421 0f0f 0012 6 0 0 3 1 0 0 0 0  0 0000 1 3 0842 0 0000
2 0 0000 8421 0f0f 0012 7 0 0 0 1 0 0 0 0  0 0000 1 0 c210 0 0000
2 0 0000 8421 0f0f 0012 8 0 0 1 1 0 0 0 0  0 0000 1 1 1200 0 0000
2 0 0000 8421 0f0f 0012 9 0 0 2 1 0 0 0 0  0 0000 1 2 0f0f 0 0000
2 0 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
3 0 0000 0020 beef 0000 6 0 0 0 0 0 1 0 0  0 0000 0 0 0000 0 0000
3 0 0000 0020 0000 0000 6 0 0 2 1 1 0 1 0  0 0000 1 2 beef 0 0000
3 0 0000 0021 1357 0000 6 0 0 0 0 0 1 0 0  0 0000 0 0 0000 0 0000
3 0 0000 0020 0000 0000 6 0 0 3 1 1 0 1 0  0 0000 1 3 beef 0 0000
3 0 0000 0021 0000 0000 6 0 0 1 1 1 0 1 0  0 0000 1 1 1357 0 0000
3 0 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
4 0 0100 0003 0004 0005 0 0 1 0 0 0 0 0 0  1 0106 0 0 0000 0 0000
4 0 0100 0004 0004 0005 0 0 1 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
4 0 0200 0004 0004 fffe 0 1 1 0 0 0 0 0 0  1 01ff 0 0 0000 0 0000
4 0 0200 0003 0004 fffe 0 1 1 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
4 0 0300 0005 0000 0010 0 2 1 0 0 0 0 0 0  1 0311 0 0 0000 0 0000
4 0 0300 0000 0000 0010 0 2 1 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
4 0 0400 8000 0000 0001 0 3 1 0 0 0 0 0 0  1 0402 0 0 0000 0 0000
4 0 0400 7fff 0000 0001 0 3 1 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
4 0 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
5 0 0000 0030 1111 0000 6 0 0 0 0 0 1 0 0  0 0000 0 0 0000 0 0000
5 1 0000 0030 2222 0000 6 0 0 0 0 0 1 0 0  0 0000 0 0 0000 0 0000
5 1 0500 0001 0002 0003 0 0 1 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
5 1 0000 0005 0006 0000 0 0 0 3 1 0 0 0 0  0 0000 0 0 0000 0 0000
5 1 0000 0077 0000 0000 0 0 0 0 0 0 0 0 1  0 0000 0 0 0000 0 0000
5 0 0000 0030 0000 0000 6 0 0 1 1 1 0 1 0  0 0000 1 1 1111 0 0000
5 0 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0  0 0000 0 0 0000 0 0000
6 0 0000 abcd 0000 0000 0 0 0 0 0 0 0 0 1  0 0000 0 0 0000 1 abcd
6 0 0000 0042 0000 0000 0 0 0 0 0 0 0 0 1  0 0000 0 0 0000 1 0042
6 0 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0  0 0000 0 0 0000 0 0000

/* verif/exec_mem_tb.sv */
`timescale 1ns/100ps

module exec_mem_tb;

    localparam int clk_period = 40;
    localparam int max_lines  = 64;
    localparam int num_fields = 22;

    typedef struct packed {
        logic [3:0]                    test;
        logic                          flush;
        cpu_pkg::id_ex_t               id_ex;
        logic                          redirect_valid;
        logic [cpu_pkg::word_size-1:0] redirect_target;
        logic                          reg_write;
        logic [1:0]                    rd;
        logic [cpu_pkg::word_size-1:0] wb_data;
        logic                          wwd_valid;
        logic [cpu_pkg::word_size-1:0] wwd_data;
    } stim_line_t;

    logic                          clk;
    logic                          reset_n;
    logic                          flush;
    cpu_pkg::id_ex_t               id_ex;
    logic                          redirect_valid;
    logic [cpu_pkg::word_size-1:0] redirect_target;
    cpu_pkg::mem_wb_t              wb;
    logic                          wwd_valid;
    logic [cpu_pkg::word_size-1:0] wwd_data;

    stim_line_t lines [max_lines];
    int         num_lines;
    bit         loaded;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         test_errors [16];
    string      test_names [16];

    exec_mem_top uut (
        .clk             (clk),
        .reset_n         (reset_n),
        .flush           (flush),
        .id_ex           (id_ex),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .wb              (wb),
        .wwd_valid       (wwd_valid),
        .wwd_data        (wwd_data)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic load_stim();
        int          fd;
        int          n;
        string       text;
        logic [31:0] f [num_fields];
        stim_line_t  s;
        fd = $fopen("verif/exec_mem_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/exec_mem_stim.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (text.len() < 3 || text.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(text,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                    f[21]);
                if (n != num_fields || num_lines >= max_lines) begin
                    $display("Stim line could not be used: %s", text);
                    errors++;
                    continue;
                end
                s.test                 = f[0][3:0];
                s.flush                = f[1][0];
                s.id_ex.pc             = f[2][cpu_pkg::word_size-1:0];
                s.id_ex.a              = f[3][cpu_pkg::word_size-1:0];
                s.id_ex.b              = f[4][cpu_pkg::word_size-1:0];
                s.id_ex.imm            = f[5][cpu_pkg::word_size-1:0];
                s.id_ex.alu_op         = cpu_pkg::alu_op_t'(f[6][3:0]);
                s.id_ex.br_op          = cpu_pkg::br_op_t'(f[7][1:0]);
                s.id_ex.is_branch      = f[8][0];
                s.id_ex.rd             = f[9][1:0];
                s.id_ex.reg_write      = f[10][0];
                s.id_ex.mem_read       = f[11][0];
                s.id_ex.mem_write      = f[12][0];
                s.id_ex.mem_to_reg     = f[13][0];
                s.id_ex.is_wwd         = f[14][0];
                s.redirect_valid       = f[15][0];
                s.redirect_target      = f[16][cpu_pkg::word_size-1:0];
                s.reg_write            = f[17][0];
                s.rd                   = f[18][1:0];
                s.wb_data              = f[19][cpu_pkg::word_size-1:0];
                s.wwd_valid            = f[20][0];
                s.wwd_data             = f[21][cpu_pkg::word_size-1:0];
                lines[num_lines]       = s;
                num_lines++;
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic report_mismatch(string name, logic [15:0] got, logic [15:0] want, int idx);
        $display("[ERROR] %s got %h expected %h (stim line %0d, test %0d)",
                 name, got, want, idx, lines[idx].test);
        errors++;
        test_errors[lines[idx].test]++;
    endtask

    task automatic compare_redirect(int idx);
        stim_line_t want;
        want = lines[idx];
        checks++;
        if (redirect_valid !== want.redirect_valid) begin
            report_mismatch("redirect_valid", 16'(redirect_valid), 16'(want.redirect_valid), idx);
        end
        if (want.redirect_valid && redirect_target !== want.redirect_target) begin
            report_mismatch("redirect_target", redirect_target, want.redirect_target, idx);
        end
    endtask

    task automatic check_writeback(int idx);
        stim_line_t want;
        want = lines[idx];
        checks++;
        if (wb.reg_write !== want.reg_write) begin
            report_mismatch("wb.reg_write", 16'(wb.reg_write), 16'(want.reg_write), idx);
        end
        if (want.reg_write && wb.rd !== want.rd) begin
            report_mismatch("wb.rd", 16'(wb.rd), 16'(want.rd), idx);
        end
        if (want.reg_write && wb.wb_data !== want.wb_data) begin
            report_mismatch("wb.wb_data", wb.wb_data, want.wb_data, idx);
        end
        if (wwd_valid !== want.wwd_valid) begin
            report_mismatch("wwd_valid", 16'(wwd_valid), 16'(want.wwd_valid), idx);
        end
        if (want.wwd_valid && wwd_data !== want.wwd_data) begin
            report_mismatch("wwd_data", wwd_data, want.wwd_data, idx);
        end
    endtask

    // Last line of a group closes its test.
    task automatic close_test(int idx);
        int t;
        t = int'(lines[idx].test);
        if (idx == num_lines - 1 || lines[idx + 1].test != lines[idx].test) begin
            tests_run++;
            if (test_errors[t] == 0) begin
                $display("Test %0d (%s): ok", t, test_names[t]);
            end else begin
                tests_failed++;
                $display("Test %0d (%s): %0d errors", t, test_names[t], test_errors[t]);
            end
        end
    endtask

    initial begin
        int k;
        int assert_fails;
        clk           = 1'b0;
        reset_n       = 1'b1;  // Active high.
        flush         = 1'b0;
        id_ex         = '0;
        test_names[1] = "reset idle";
        test_names[2] = "alu operations";
        test_names[3] = "store and load";
        test_names[4] = "branches";
        test_names[5] = "flush";
        test_names[6] = "wwd output";
        load_stim();
        if (num_lines == 0) begin
            $display("No stimulus lines were read, nothing was tested");
            errors++;
        end else begin
            repeat (8) @(posedge clk);
            for (k = 0; k < num_lines + 2; k++) begin
                @(negedge clk);
                if (k == 0) begin
                    reset_n = 1'b0;
                    if (redirect_valid !== 1'b0 || wb.reg_write !== 1'b0 ||
                        wwd_valid !== 1'b0) begin
                        $display("Outputs were active after reset before any instruction");
                        errors++;
                        test_errors[lines[0].test]++;
                    end
                end
                if (k >= 1 && k <= num_lines) begin
                    compare_redirect(k - 1);  // Redirect lags one edge.
                end
                if (k >= 2) begin
                    check_writeback(k - 2);  // Write-back lags two edges.
                    close_test(k - 2);
                end
                if (k < num_lines) begin
                    flush = lines[k].flush;
                    id_ex = lines[k].id_ex;
                end else begin
                    flush = 1'b0;
                    id_ex = '0;
                end
            end
            repeat (3) @(negedge clk);
        end
        assert_fails = uut.u_asserts.fail_count;
        $display("Done: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((num_lines + 20) * clk_period);
        $display("Timeout: the run did not end within %0d clock cycles", num_lines + 20);
        $display("Test failures found");
        $finish;
    end

endmodule

/* verif/exec_mem_asserts.sv */
`timescale 1ns/100ps

module exec_mem_asserts (
    input logic clk,
    input logic reset_n,
    input logic flush,
    input logic redirect_valid,
    input logic wwd_valid,
    input logic wb_reg_write
);

    int fail_count = 0;  // Read by the testbench at the end.

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset_n) |-> (!redirect_valid && !wwd_valid) ##1 !wwd_valid)
        else begin
            $error("redirect_valid or wwd_valid active right after reset");
            fail_count++;
        end

    // A killed bundle never redirects.
    flush_no_redirect: assert property (@(posedge clk) disable iff (reset_n)
        flush |=> !redirect_valid)
        else begin
            $error("redirect_valid raised after a flush");
            fail_count++;
        end

    flush_no_wwd: assert property (@(posedge clk) disable iff (reset_n)
        flush |-> ##2 !wwd_valid)
        else begin
            $error("wwd_valid raised two cycles after a flush");
            fail_count++;
        end

    reg_write_known: assert property (@(posedge clk) disable iff (reset_n)
        !$isunknown(wb_reg_write))
        else begin
            $error("wb.reg_write is unknown");
            fail_count++;
        end

endmodule

bind exec_mem_top exec_mem_asserts u_asserts (
    .clk            (clk),
    .reset_n        (reset_n),
    .flush          (flush),
    .redirect_valid (redirect_valid),
    .wwd_valid      (wwd_valid),
    .wb_reg_write   (wb.reg_write)
);

/* logic/exec_mem_top.sv */
`timescale 1ns/100ps

module exec_mem_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          flush,
    input  cpu_pkg::id_ex_t               id_ex,
    output logic                          redirect_valid,
    output logic [cpu_pkg::word_size-1:0] redirect_target,
    output cpu_pkg::mem_wb_t              wb,
    output logic                          wwd_valid,
    output logic [cpu_pkg::word_size-1:0] wwd_data
);

    cpu_pkg::ex_mem_t ex_next;
    cpu_pkg::ex_mem_t ex_mem_q;

    exec_stage u_exec (
        .id_ex  (id_ex),
        .ex_out (ex_next)
    );

    pipe_reg #(
        .payload_t (cpu_pkg::ex_mem_t),
        .bubble    (cpu_pkg::ex_mem_bubble)
    ) ex_mem_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (flush),
        .d       (ex_next),
        .q       (ex_mem_q)
    );

    mem_stage u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .ex_mem  (ex_mem_q),
        .wb      (wb)
    );

    // Redirect leaves one cycle after EX.
    assign redirect_valid  = ex_mem_q.branch_taken;
    assign redirect_target = ex_mem_q.target;

    assign wwd_valid = wb.is_wwd;
    assign wwd_data  = wb.wwd_data;

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
    input  logic             clk,
    input  logic             reset_n,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::mem_wb_t wb
);

    logic [cpu_pkg::word_size-1:0]  mem [cpu_pkg::mem_depth];
    logic [cpu_pkg::mem_addr_w-1:0] addr;
    logic [cpu_pkg::word_size-1:0]  load_data;
    cpu_pkg::mem_wb_t               wb_next;

    assign addr = ex_mem.alu_result[cpu_pkg::mem_addr_w-1:0];

    // Store lands at the edge, so the next load sees it.
    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            mem[addr] <= ex_mem.store_data;
        end
    end

    assign load_data = ex_mem.mem_read ? mem[addr] : '0;  // Asynchronous read.

    always_comb begin
        wb_next.wb_data   = ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;
        wb_next.rd        = ex_mem.rd;
        wb_next.reg_write = ex_mem.reg_write;
        wb_next.is_wwd    = ex_mem.is_wwd;
        wb_next.wwd_data  = ex_mem.wwd_data;
    end

    pipe_reg #(
        .payload_t (cpu_pkg::mem_wb_t),
        .bubble    (cpu_pkg::mem_wb_bubble)
    ) mem_wb_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (1'b0),  // Nothing to kill past MEM.
        .d       (wb_next),
        .q       (wb)
    );

endmodule

/* logic/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage (
    input  cpu_pkg::id_ex_t  id_ex,
    output cpu_pkg::ex_mem_t ex_out
);

    logic [cpu_pkg::word_size-1:0] alu_result;
    logic [cpu_pkg::word_size-1:0] target;
    logic                          cond;
    logic                          a_neg;
    logic                          a_zero;

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::alu_add:    alu_result = id_ex.a + id_ex.b;
            cpu_pkg::alu_sub:    alu_result = id_ex.a - id_ex.b;
            cpu_pkg::alu_and:    alu_result = id_ex.a & id_ex.b;
            cpu_pkg::alu_orr:    alu_result = id_ex.a | id_ex.b;
            cpu_pkg::alu_not:    alu_result = ~id_ex.a;
            cpu_pkg::alu_tcp:    alu_result = ~id_ex.a + cpu_pkg::word_size'(1);
            cpu_pkg::alu_shl:    alu_result = id_ex.a << 1;
            cpu_pkg::alu_shr: begin
                alu_result = {id_ex.a[cpu_pkg::word_size-1], id_ex.a[cpu_pkg::word_size-1:1]};
            end
            cpu_pkg::alu_lhi:    alu_result = id_ex.imm << (cpu_pkg::word_size / 2);
            cpu_pkg::alu_pass_b: alu_result = id_ex.b;
            default:             alu_result = '0;  // Unused codes.
        endcase
    end

    assign a_neg  = id_ex.a[cpu_pkg::word_size-1];
    assign a_zero = (id_ex.a == '0);

    // Condition is evaluated for every op, gated by is_branch below.
    always_comb begin
        case (id_ex.br_op)
            cpu_pkg::br_ne: cond = (id_ex.a != id_ex.b);
            cpu_pkg::br_eq: cond = (id_ex.a == id_ex.b);
            cpu_pkg::br_gz: cond = !a_neg && !a_zero;
            cpu_pkg::br_lz: cond = a_neg;
            default:        cond = 1'b0;
        endcase
    end

    assign target = id_ex.pc + cpu_pkg::word_size'(1) + id_ex.imm;  // Relative to next pc.

    always_comb begin
        ex_out.alu_result   = alu_result;
        ex_out.store_data   = id_ex.b;
        ex_out.rd           = id_ex.rd;
        ex_out.reg_write    = id_ex.reg_write;
        ex_out.mem_read     = id_ex.mem_read;
        ex_out.mem_write    = id_ex.mem_write;
        ex_out.mem_to_reg   = id_ex.mem_to_reg;
        ex_out.is_wwd       = id_ex.is_wwd;
        ex_out.wwd_data     = id_ex.a;  // Output port shows operand a.
        ex_out.branch_taken = id_ex.is_branch && cond;
        ex_out.target       = target;
    end

endmodule

/* logic/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t bubble    = '0
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush kills the bundle captured at this edge.
    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            q <= bubble;
        end else begin
            q <= d;
        end
    end

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_size  = 16;
    localparam int mem_depth  = 256;
    localparam int mem_addr_w = $clog2(mem_depth);  // Low bits of the ALU result.

    typedef enum logic [3:0] {
        alu_add    = 4'h0,
        alu_sub    = 4'h1,
        alu_and    = 4'h2,
        alu_orr    = 4'h3,
        alu_not    = 4'h4,
        alu_tcp    = 4'h5,  // Two's complement of a.
        alu_shl    = 4'h6,
        alu_shr    = 4'h7,  // Arithmetic shift keeps the sign.
        alu_lhi    = 4'h8,  // Immediate into the upper byte.
        alu_pass_b = 4'h9
    } alu_op_t;

    typedef enum logic [1:0] {
        br_ne = 2'd0,
        br_eq = 2'd1,
        br_gz = 2'd2,  // a against zero.
        br_lz = 2'd3
    } br_op_t;

    typedef struct packed {
        logic [word_size-1:0] pc;
        logic [word_size-1:0] a;
        logic [word_size-1:0] b;
        logic [word_size-1:0] imm;
        alu_op_t              alu_op;
        br_op_t               br_op;
        logic                 is_branch;
        logic [1:0]           rd;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 is_wwd;
    } id_ex_t;

    typedef struct packed {
        logic [word_size-1:0] alu_result;
        logic [word_size-1:0] store_data;
        logic [1:0]           rd;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 is_wwd;
        logic [word_size-1:0] wwd_data;
        logic                 branch_taken;
        logic [word_size-1:0] target;
    } ex_mem_t;

    typedef struct packed {
        logic [word_size-1:0] wb_data;
        logic [1:0]           rd;
        logic                 reg_write;
        logic                 is_wwd;
        logic [word_size-1:0] wwd_data;
    } mem_wb_t;

    localparam ex_mem_t ex_mem_bubble = '0;  // No write, no store, no redirect.
    localparam mem_wb_t mem_wb_bubble = '0;

endpackage
